// File: files.f
+incdir+.
match_pkg.sv
start_conditioner.sv
key_decoder.sv
match_engine.sv
vga_timing.sv
tile_address.sv
pixel_output.sv
match_top.sv
match_checker.sv
tb_match_top.sv

// File: key_decoder.sv
`timescale 1ns/1ps
`include "match_cfg.svh"

module key_decoder import match_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       key_valid_i,
    input  scan_code_t key_code_i,
    output logic       tile_hit_o,
    output tile_idx_t  tile_o,
    output logic       shift_hit_o,
    output logic       enter_hit_o
);

    localparam scan_code_t TILE_KEYS [`NUM_TILES] = '{
        `KEY_T0, `KEY_T1, `KEY_T2, `KEY_T3,
        `KEY_T4, `KEY_T5, `KEY_T6, `KEY_T7,
        `KEY_T8, `KEY_T9, `KEY_T10, `KEY_T11,
        `KEY_T12, `KEY_T13, `KEY_T14, `KEY_T15
    };

    logic      tile_match;
    tile_idx_t tile_num;

    always_comb begin
        tile_match = 1'b0;
        tile_num   = '0;
        for (int i = 0; i < `NUM_TILES; i++) begin
            if (key_code_i == TILE_KEYS[i]) begin
                tile_match = 1'b1;
                tile_num   = tile_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_hit_o  <= 1'b0;
            shift_hit_o <= 1'b0;
            enter_hit_o <= 1'b0;
        end else begin
            tile_hit_o  <= key_valid_i && tile_match;
            shift_hit_o <= key_valid_i && (key_code_i == `KEY_SHIFT);
            enter_hit_o <= key_valid_i && (key_code_i == `KEY_ENTER);
        end
    end

    always_ff @(posedge clk) begin
        if (key_valid_i) begin
            tile_o <= tile_num;
        end
    end

    a_one_cmd: assert property (@(posedge clk) disable iff (rst)
        $onehot0({tile_hit_o, shift_hit_o, enter_hit_o}));

endmodule

// File: match_cfg.svh
`ifndef MATCH_CFG_SVH
`define MATCH_CFG_SVH

// 640x480 at one pixel per clock
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL 800

`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL 525

// Tile size is in half-resolution coordinates
`define TILE_W 80
`define TILE_H 60
`define GRID_DIM 4
`define NUM_TILES 16
`define NUM_IMAGES 8

`define KEY_ENTER 9'h05A
`define KEY_SHIFT 9'h012

// Row by row: 1 2 3 4, Q W E R, A S D F, Z X C V
`define KEY_T0 9'h016
`define KEY_T1 9'h01E
`define KEY_T2 9'h026
`define KEY_T3 9'h025
`define KEY_T4 9'h015
`define KEY_T5 9'h01D
`define KEY_T6 9'h024
`define KEY_T7 9'h02D
`define KEY_T8 9'h01C
`define KEY_T9 9'h01B
`define KEY_T10 9'h023
`define KEY_T11 9'h02B
`define KEY_T12 9'h01A
`define KEY_T13 9'h022
`define KEY_T14 9'h021
`define KEY_T15 9'h02A

`define DEBOUNCE_LEN 7

`endif

// File: match_checker.sv
`timescale 1ns/1ps
`include "match_cfg.svh"

module match_checker import match_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_i,
    input  logic                  hint_i,
    input  logic                  key_valid_i,
    input  scan_code_t            key_code_i,
    input  game_phase_t           phase_i,
    input  logic                  pass_i,
    input  logic [`NUM_TILES-1:0] shown_i,
    input  pix_addr_t             addr_i,
    input  rgb_t                  rgb_i,
    input  logic                  hsync_i,
    input  logic                  vsync_i
);

    localparam int FRAME = `H_TOTAL * `V_TOTAL;

    // Game model state
    game_phase_t  phase_m;
    logic         pass_m;
    tile_status_t st_m [`NUM_TILES];
    logic [`NUM_TILES-1:0] flip_m;
    int           wins_m;
    int           last_m;
    logic         last_vld_m;
    int           run_m;
    logic         pulse_pend;
    logic         pulse_m;
    int           cmd_kind;
    int           cmd_tile;
    int           auto_fail = 0;

    string test_name = "reset";
    int    man_fail = 0;
    int    auto_base = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    total_errors = 0;

    function automatic int key_tile(scan_code_t c);
        scan_code_t keys [`NUM_TILES];
        keys = '{`KEY_T0, `KEY_T1, `KEY_T2, `KEY_T3, `KEY_T4, `KEY_T5, `KEY_T6, `KEY_T7,
                 `KEY_T8, `KEY_T9, `KEY_T10, `KEY_T11, `KEY_T12, `KEY_T13, `KEY_T14, `KEY_T15};
        for (int i = 0; i < `NUM_TILES; i++) begin
            if (keys[i] == c) return i;
        end
        return -1;
    endfunction

    function automatic logic [`NUM_TILES-1:0] shown_model(logic hint);
        logic [`NUM_TILES-1:0] s;
        s = '1;
        if (phase_m == INIT) s = '0;
        if (phase_m == GAME && !hint) begin
            for (int i = 0; i < `NUM_TILES; i++) s[i] = (st_m[i] != CLOSED);
        end
        return s;
    endfunction

    // Word address inside the tile image for a visible pixel
    function automatic int pixel_addr(int line, int x);
        int hx;
        int tile;
        int ly;
        hx   = x / 2;
        tile = ((line / 2) / `TILE_H) * `GRID_DIM + hx / `TILE_W;
        ly   = (line / 2) % `TILE_H;
        if (flip_m[tile % `NUM_TILES]) ly = `TILE_H - 1 - ly;
        return hx % `TILE_W + ly * `TILE_W;
    endfunction

    task automatic clear_game();
        for (int i = 0; i < `NUM_TILES; i++) st_m[i] = CLOSED;
        flip_m     = `NUM_TILES'(16'h000D);
        wins_m     = 0;
        last_vld_m = 1'b0;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_m = INIT;
            pass_m  = 1'b0;
            clear_game();
            last_m = 0;
            run_m = 0;
            pulse_pend = 1'b0;
            pulse_m = 1'b0;
            cmd_kind = 0;
            cmd_tile = 0;
        end else begin
            if (phase_i !== phase_m || pass_i !== pass_m || shown_i !== shown_model(hint_i)) begin
                auto_fail = auto_fail + 1;
                if (auto_fail <= 10) begin
                    $display("[FAIL] %s: phase/pass/shown expected %0d/%0d/%h, actual %0d/%0d/%h",
                             test_name, int'(phase_m), pass_m, shown_model(hint_i),
                             int'(phase_i), pass_i, shown_i);
                end
            end
            case (phase_m)
                INIT, SHOW: begin
                    clear_game();
                    if (pulse_m) phase_m = (phase_m == INIT) ? SHOW : GAME;
                end
                GAME: begin
                    if (!hint_i && cmd_kind == 1 && !(last_vld_m && cmd_tile == last_m)) begin
                        if (st_m[cmd_tile] == CLOSED) st_m[cmd_tile] = OPENED;
                        if (last_vld_m && last_m == (cmd_tile + 8) % 16
                            && st_m[cmd_tile] != MATCHED && st_m[last_m] != MATCHED
                            && flip_m[cmd_tile] == flip_m[last_m]) begin
                            st_m[cmd_tile] = MATCHED;
                            st_m[last_m]   = MATCHED;
                            wins_m = wins_m + 1;
                        end
                        last_m = cmd_tile;
                        last_vld_m = 1'b1;
                    end else if (!hint_i && cmd_kind == 2 && last_vld_m) begin
                        flip_m[last_m] = ~flip_m[last_m];
                    end else if (!hint_i && cmd_kind == 3) begin
                        for (int i = 0; i < `NUM_TILES; i++) begin
                            if (st_m[i] == OPENED) st_m[i] = CLOSED;
                        end
                        last_vld_m = 1'b0;
                    end
                    if (wins_m == `NUM_IMAGES) begin
                        phase_m = FINISH;
                        pass_m  = 1'b1;
                    end
                end
                default: begin
                    if (pulse_m) begin
                        phase_m = INIT;
                        pass_m  = 1'b0;
                    end
                end
            endcase

            // Decoder and debounce delays
            cmd_kind = 0;
            if (key_valid_i) begin
                cmd_tile = key_tile(key_code_i);
                if (cmd_tile >= 0) cmd_kind = 1;
                else if (key_code_i == `KEY_SHIFT) cmd_kind = 2;
                else if (key_code_i == `KEY_ENTER) cmd_kind = 3;
            end
            if (cmd_tile < 0) cmd_tile = 0;
            run_m = start_i ? ((run_m > `DEBOUNCE_LEN) ? run_m : run_m + 1) : 0;
            pulse_m = pulse_pend;
            pulse_pend = (run_m == `DEBOUNCE_LEN);
        end
    end

    task automatic begin_test(string name);
        test_name = name;
        man_fail  = 0;
        auto_base = auto_fail;
    endtask

    task automatic end_test();
        int errs;
        errs = man_fail + auto_fail - auto_base;
        tests_run = tests_run + 1;
        total_errors = total_errors + errs;
        if (errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed = tests_failed + 1;
            $display("test %s: %0d errors", test_name, errs);
        end
    endtask

    task automatic expect_value(string what, int exp, int act);
        if (exp != act) begin
            man_fail = man_fail + 1;
            $display("[FAIL] %s: %s expected %0h, actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic check_frame_black();
        int bad;
        bad = 0;
        repeat (FRAME) begin
            @(negedge clk);
            if (rgb_i !== '0) bad++;
        end
        expect_value("non-black pixels", 0, bad);
    endtask

    task automatic check_sync_frame();
        int hlow;
        int vlow;
        int hfall;
        logic prev_h;
        hlow = 0;
        vlow = 0;
        hfall = 0;
        prev_h = hsync_i;
        repeat (FRAME) begin
            @(negedge clk);
            if (!hsync_i) hlow++;
            if (!vsync_i) vlow++;
            if (prev_h && !hsync_i) hfall++;
            prev_h = hsync_i;
        end
        expect_value("hsync low cycles", `H_SYNC * `V_TOTAL, hlow);
        expect_value("vsync low cycles", `V_SYNC * `H_TOTAL, vlow);
        expect_value("hsync pulses", `V_TOTAL, hfall);
    endtask

    // Checks one visible line against the memory model pattern
    task automatic check_show_line(int line);
        logic prev;
        int n;
        int tile;
        int exp;
        prev = vsync_i;
        forever begin
            @(negedge clk);
            if (!prev && vsync_i) break;
            prev = vsync_i;
        end
        n = 0;
        prev = hsync_i;
        while (n < `V_BACK + line) begin
            @(negedge clk);
            if (!prev && hsync_i) n++;
            prev = hsync_i;
        end
        repeat (`H_BACK) @(negedge clk);
        // The address leads the color by two pixels
        for (int x = 0; x < `H_TOTAL; x++) begin
            tile = ((line / 2) / `TILE_H) * `GRID_DIM + (x / 2) / `TILE_W;
            exp  = ((tile % `NUM_IMAGES) << 9) | (pixel_addr(line, x) & 511);
            if (x >= `H_ACTIVE) exp = 0;
            if (int'(rgb_i) != exp) expect_value($sformatf("pixel %0d", x), exp, int'(rgb_i));
            if (x + 2 < `H_ACTIVE) begin
                expect_value($sformatf("address %0d", x + 2), pixel_addr(line, x + 2),
                             int'(addr_i));
            end
            @(negedge clk);
        end
    endtask

    task automatic final_report();
        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
    endtask

endmodule

// File: match_engine.sv
`timescale 1ns/1ps
`include "match_cfg.svh"

module match_engine import match_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  start_pulse_i,
    input  logic                  hint_i,
    input  logic                  tile_hit_i,
    input  tile_idx_t             tile_i,
    input  logic                  shift_hit_i,
    input  logic                  enter_hit_i,
    output logic [`NUM_TILES-1:0] tile_flip_o,
    output logic [`NUM_TILES-1:0] tile_shown_o,
    output game_phase_t           phase_o,
    output logic                  pass_o
);

    // Tiles 0, 2 and 3 start upside down
    localparam logic [`NUM_TILES-1:0] INIT_FLIP = `NUM_TILES'(16'h000D);
    localparam int WIN_W = $clog2(`NUM_IMAGES + 1);

    game_phase_t  phase_nxt;
    tile_status_t status_q [`NUM_TILES];
    logic [WIN_W-1:0] win_q;
    logic [WIN_W-1:0] win_nxt;
    tile_idx_t    last_q;
    logic         last_vld_q;
    tile_idx_t    partner;
    logic         key_en;
    logic         new_tile;
    logic         pair_ok;

    assign partner  = tile_idx_t'(tile_i + `NUM_IMAGES);
    assign key_en   = (phase_o == GAME) && !hint_i;
    assign new_tile = key_en && tile_hit_i && !(last_vld_q && tile_i == last_q);
    assign pair_ok  = new_tile && last_vld_q && (last_q == partner)
                      && (status_q[tile_i] != MATCHED) && (status_q[last_q] != MATCHED)
                      && (tile_flip_o[tile_i] == tile_flip_o[last_q]);
    assign win_nxt  = win_q + WIN_W'(pair_ok);

    always_comb begin
        phase_nxt = phase_o;
        case (phase_o)
            INIT:   if (start_pulse_i) phase_nxt = SHOW;
            SHOW:   if (start_pulse_i) phase_nxt = GAME;
            GAME:   if (win_nxt == WIN_W'(`NUM_IMAGES)) phase_nxt = FINISH;
            FINISH: if (start_pulse_i) phase_nxt = INIT;
            default: phase_nxt = INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_o     <= INIT;
            pass_o      <= 1'b0;
            tile_flip_o <= INIT_FLIP;
            win_q       <= '0;
            last_q      <= '0;
            last_vld_q  <= 1'b0;
            for (int i = 0; i < `NUM_TILES; i++) status_q[i] <= CLOSED;
        end else begin
            phase_o <= phase_nxt;
            if (phase_nxt == FINISH) begin
                pass_o <= 1'b1;
            end else if (phase_nxt == INIT) begin
                pass_o <= 1'b0;
            end

            if (phase_o == INIT || phase_o == SHOW) begin
                tile_flip_o <= INIT_FLIP;
                win_q       <= '0;
                last_vld_q  <= 1'b0;
                for (int i = 0; i < `NUM_TILES; i++) status_q[i] <= CLOSED;
            end else begin
                win_q <= win_nxt;
                if (new_tile) begin
                    if (status_q[tile_i] == CLOSED) status_q[tile_i] <= OPENED;
                    if (pair_ok) begin
                        status_q[tile_i] <= MATCHED;
                        status_q[last_q] <= MATCHED;
                    end
                    last_q     <= tile_i;
                    last_vld_q <= 1'b1;
                end else if (key_en && shift_hit_i && last_vld_q) begin
                    tile_flip_o[last_q] <= ~tile_flip_o[last_q];
                end else if (key_en && enter_hit_i) begin
                    // Unmatched tiles turn back over
                    for (int i = 0; i < `NUM_TILES; i++) begin
                        if (status_q[i] == OPENED) status_q[i] <= CLOSED;
                    end
                    last_vld_q <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < `NUM_TILES; i++) begin
            case (phase_o)
                INIT:    tile_shown_o[i] = 1'b0;
                GAME:    tile_shown_o[i] = hint_i || (status_q[i] != CLOSED);
                default: tile_shown_o[i] = 1'b1;
            endcase
        end
    end

    a_win_bound: assert property (@(posedge clk) disable iff (rst)
        win_q <= WIN_W'(`NUM_IMAGES));

endmodule

// File: match_pkg.sv
`include "match_cfg.svh"

package match_pkg;

    typedef logic [8:0] scan_code_t;
    typedef logic [$clog2(`NUM_TILES)-1:0] tile_idx_t;
    typedef logic [$clog2(`NUM_IMAGES)-1:0] img_id_t;
    typedef logic [$clog2(`TILE_W * `TILE_H)-1:0] pix_addr_t;
    typedef logic [11:0] rgb_t;
    typedef logic [$clog2(`H_TOTAL)-1:0] screen_t;

    typedef enum logic [1:0] {
        INIT,
        SHOW,
        GAME,
        FINISH
    } game_phase_t;

    typedef enum logic [1:0] {
        CLOSED,
        OPENED,
        MATCHED
    } tile_status_t;

endpackage

// File: match_top.sv
`timescale 1ns/1ps
`include "match_cfg.svh"

module match_top import match_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_i,
    input  logic        hint_i,
    input  logic        key_valid_i,
    input  scan_code_t  key_code_i,
    input  rgb_t        img_data_i,
    output img_id_t     img_id_o,
    output pix_addr_t   img_addr_o,
    output rgb_t        rgb_o,
    output logic        hsync_o,
    output logic        vsync_o,
    output logic        pass_o,
    output game_phase_t phase_o
);

    logic                  start_pulse;
    logic                  tile_hit;
    tile_idx_t             tile;
    logic                  shift_hit;
    logic                  enter_hit;
    logic [`NUM_TILES-1:0] tile_flip;
    logic [`NUM_TILES-1:0] tile_shown;
    screen_t               hcount;
    screen_t               vcount;
    logic                  vga_active;
    logic                  vga_hsync;
    logic                  vga_vsync;
    tile_idx_t             addr_tile;
    logic                  addr_active;
    logic                  addr_hsync;
    logic                  addr_vsync;

    start_conditioner start_i0 (
        .clk(clk), .rst(rst), .btn_i(start_i), .pulse_o(start_pulse)
    );

    key_decoder keys_i0 (
        .clk(clk), .rst(rst), .key_valid_i(key_valid_i), .key_code_i(key_code_i),
        .tile_hit_o(tile_hit), .tile_o(tile), .shift_hit_o(shift_hit),
        .enter_hit_o(enter_hit)
    );

    match_engine engine_i0 (
        .clk(clk), .rst(rst), .start_pulse_i(start_pulse), .hint_i(hint_i),
        .tile_hit_i(tile_hit), .tile_i(tile), .shift_hit_i(shift_hit),
        .enter_hit_i(enter_hit), .tile_flip_o(tile_flip), .tile_shown_o(tile_shown),
        .phase_o(phase_o), .pass_o(pass_o)
    );

    vga_timing timing_i0 (
        .clk(clk), .rst(rst), .hcount_o(hcount), .vcount_o(vcount),
        .active_o(vga_active), .hsync_o(vga_hsync), .vsync_o(vga_vsync)
    );

    tile_address addr_i0 (
        .clk(clk), .rst(rst), .hcount_i(hcount), .vcount_i(vcount),
        .active_i(vga_active), .hsync_i(vga_hsync), .vsync_i(vga_vsync),
        .tile_flip_i(tile_flip), .img_id_o(img_id_o), .img_addr_o(img_addr_o),
        .tile_o(addr_tile), .active_o(addr_active), .hsync_o(addr_hsync),
        .vsync_o(addr_vsync)
    );

    pixel_output pixel_i0 (
        .clk(clk), .rst(rst), .img_data_i(img_data_i), .tile_shown_i(tile_shown),
        .tile_i(addr_tile), .active_i(addr_active), .hsync_i(addr_hsync),
        .vsync_i(addr_vsync), .rgb_o(rgb_o), .hsync_o(hsync_o), .vsync_o(vsync_o)
    );

endmodule

// File: pixel_output.sv
`timescale 1ns/1ps
`include "match_cfg.svh"

module pixel_output import match_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  rgb_t                  img_data_i,
    input  logic [`NUM_TILES-1:0] tile_shown_i,
    input  tile_idx_t             tile_i,
    input  logic                  active_i,
    input  logic                  hsync_i,
    input  logic                  vsync_i,
    output rgb_t                  rgb_o,
    output logic                  hsync_o,
    output logic                  vsync_o
);

    tile_idx_t tile_q;
    logic      active_q;
    logic      hsync_q;
    logic      vsync_q;

    // Wait out the image read
    always_ff @(posedge clk) begin
        tile_q <= tile_i;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_q <= 1'b0;
            hsync_q  <= 1'b1;
            vsync_q  <= 1'b1;
            rgb_o    <= '0;
            hsync_o  <= 1'b1;
            vsync_o  <= 1'b1;
        end else begin
            active_q <= active_i;
            hsync_q  <= hsync_i;
            vsync_q  <= vsync_i;
            rgb_o    <= (active_q && tile_shown_i[tile_q]) ? img_data_i : '0;
            hsync_o  <= hsync_q;
            vsync_o  <= vsync_q;
        end
    end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_match_top -f files.f -o sim_match
./obj_dir/sim_match > sim.log 2>&1 || true
cat sim.log
if grep -q "\*\* FAIL \*\*" sim.log; then
    echo "simulation failed"
    exit 1
fi
grep -q "\*\* PASS \*\*" sim.log
echo "simulation passed"

// File: start_conditioner.sv
`timescale 1ns/1ps
`include "match_cfg.svh"

module start_conditioner (
    input  logic clk,
    input  logic rst,
    input  logic btn_i,
    output logic pulse_o
);

    logic [`DEBOUNCE_LEN-1:0] history;
    logic                     level;
    logic                     level_d;

    // Pressed only after a full run of high samples
    assign level = &history;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            history <= '0;
            level_d <= 1'b0;
            pulse_o <= 1'b0;
        end else begin
            history <= {history[`DEBOUNCE_LEN-2:0], btn_i};
            level_d <= level;
            pulse_o <= level & ~level_d;
        end
    end

    a_single_pulse: assert property (@(posedge clk) disable iff (rst) pulse_o |=> !pulse_o);

endmodule

// File: tb_match_top.sv
`timescale 1ns/1ps
`include "match_cfg.svh"

module tb_match_top;
    import match_pkg::*;

    localparam int FRAME = `H_TOTAL * `V_TOTAL;
    localparam int MAX_PRESSES = 3000;
    localparam int STIM_CYCLES = MAX_PRESSES * 10 + 4 * FRAME + 2000;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        start = 1'b0;
    logic        hint = 1'b0;
    logic        key_valid = 1'b0;
    scan_code_t  key_code = '0;
    rgb_t        img_data = '0;
    img_id_t     img_id;
    pix_addr_t   img_addr;
    rgb_t        rgb;
    logic        hsync;
    logic        vsync;
    logic        pass;
    game_phase_t phase;

    always #2 clk = ~clk;

    // Image memory with one cycle of read latency
    always @(posedge clk) img_data <= {img_id, img_addr[8:0]};

    match_top dut_i (
        .clk(clk), .rst(rst), .start_i(start), .hint_i(hint), .key_valid_i(key_valid),
        .key_code_i(key_code), .img_data_i(img_data), .img_id_o(img_id),
        .img_addr_o(img_addr), .rgb_o(rgb), .hsync_o(hsync), .vsync_o(vsync),
        .pass_o(pass), .phase_o(phase)
    );

    match_checker chk_i (
        .clk(clk), .rst(rst), .start_i(start), .hint_i(hint), .key_valid_i(key_valid),
        .key_code_i(key_code), .phase_i(phase), .pass_i(pass),
        .shown_i(dut_i.tile_shown), .addr_i(img_addr), .rgb_i(rgb), .hsync_i(hsync),
        .vsync_i(vsync)
    );

    function automatic scan_code_t tile_key(int t);
        scan_code_t keys [`NUM_TILES];
        keys = '{`KEY_T0, `KEY_T1, `KEY_T2, `KEY_T3, `KEY_T4, `KEY_T5, `KEY_T6, `KEY_T7,
                 `KEY_T8, `KEY_T9, `KEY_T10, `KEY_T11, `KEY_T12, `KEY_T13, `KEY_T14, `KEY_T15};
        return keys[t % `NUM_TILES];
    endfunction

    task automatic press_key(scan_code_t code, int gap);
        @(negedge clk);
        key_valid = 1'b1;
        key_code  = code;
        @(negedge clk);
        key_valid = 1'b0;
        repeat (gap - 1) @(negedge clk);
    endtask

    task automatic press_start();
        @(negedge clk);
        start = 1'b1;
        repeat (12) @(negedge clk);
        start = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    initial begin
        repeat (2 * FRAME + STIM_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not complete in the expected time");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int r;
        scan_code_t code;
        void'($urandom(32'hf2e));
        repeat (10) @(negedge clk);
        rst = 1'b0;

        chk_i.begin_test("reset_and_phase_flow");
        chk_i.expect_value("phase", int'(INIT), int'(phase));
        chk_i.expect_value("pass", 0, int'(pass));
        chk_i.expect_value("syncs", 3, int'({hsync, vsync}));
        press_start();
        chk_i.expect_value("phase", int'(SHOW), int'(phase));
        press_start();
        chk_i.expect_value("phase", int'(GAME), int'(phase));
        press_start();
        chk_i.expect_value("phase", int'(GAME), int'(phase));
        chk_i.end_test();

        // Tile 0 starts flipped and tile 8 does not
        chk_i.begin_test("shift_and_flip");
        press_key(tile_key(0), 3);
        press_key(tile_key(8), 3);
        chk_i.expect_value("shown", 'h0101, int'(dut_i.tile_shown));
        press_key(`KEY_ENTER, 3);
        chk_i.expect_value("shown", 0, int'(dut_i.tile_shown));
        press_key(tile_key(0), 3);
        press_key(tile_key(8), 3);
        press_key(`KEY_SHIFT, 3);
        press_key(tile_key(0), 3);
        press_key(`KEY_ENTER, 3);
        chk_i.expect_value("shown", 'h0101, int'(dut_i.tile_shown));
        chk_i.end_test();

        chk_i.begin_test("random_matching");
        for (int i = 0; i < MAX_PRESSES && chk_i.phase_m != FINISH; i++) begin
            r = $urandom_range(99);
            if (r < 30 && chk_i.last_vld_m) code = tile_key(chk_i.last_m + 8);
            else if (r < 65) code = tile_key($urandom_range(15));
            else if (r < 78) code = `KEY_SHIFT;
            else if (r < 88) code = `KEY_ENTER;
            else code = scan_code_t'(9'h100 | $urandom_range(255));
            if ($urandom_range(19) == 0) begin
                @(negedge clk);
                hint = 1'b1;
                press_key(code, $urandom_range(6, 2));
                hint = 1'b0;
            end else begin
                press_key(code, $urandom_range(6, 2));
            end
        end
        repeat (3) @(negedge clk);
        chk_i.expect_value("phase", int'(FINISH), int'(phase));
        chk_i.expect_value("pass", 1, int'(pass));
        chk_i.end_test();

        chk_i.begin_test("blanking_in_init");
        press_start();
        chk_i.expect_value("phase", int'(INIT), int'(phase));
        chk_i.check_frame_black();
        chk_i.end_test();

        chk_i.begin_test("pixels_in_show");
        press_start();
        chk_i.expect_value("phase", int'(SHOW), int'(phase));
        chk_i.check_show_line(21);
        chk_i.end_test();

        chk_i.begin_test("sync_timing");
        chk_i.check_sync_frame();
        chk_i.end_test();

        chk_i.final_report();
        if (chk_i.total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: tile_address.sv
`timescale 1ns/1ps
`include "match_cfg.svh"

module tile_address import match_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  screen_t               hcount_i,
    input  screen_t               vcount_i,
    input  logic                  active_i,
    input  logic                  hsync_i,
    input  logic                  vsync_i,
    input  logic [`NUM_TILES-1:0] tile_flip_i,
    output img_id_t               img_id_o,
    output pix_addr_t             img_addr_o,
    output tile_idx_t             tile_o,
    output logic                  active_o,
    output logic                  hsync_o,
    output logic                  vsync_o
);

    localparam int GRID_W = $clog2(`GRID_DIM);
    localparam int LX_W   = $clog2(`TILE_W);
    localparam int LY_W   = $clog2(`TILE_H);

    screen_t           x;
    screen_t           y;
    logic [GRID_W-1:0] col;
    logic [GRID_W-1:0] row;
    tile_idx_t         tile;
    logic [LX_W-1:0]   lx;
    logic [LY_W-1:0]   ly_raw;
    logic [LY_W-1:0]   ly;

    // Each image pixel covers a 2x2 screen block
    assign x      = hcount_i >> 1;
    assign y      = vcount_i >> 1;
    assign col    = GRID_W'(x / `TILE_W);
    assign row    = GRID_W'(y / `TILE_H);
    assign tile   = tile_idx_t'(row * `GRID_DIM + col);
    assign lx     = LX_W'(x % `TILE_W);
    assign ly_raw = LY_W'(y % `TILE_H);
    assign ly     = tile_flip_i[tile] ? LY_W'(`TILE_H - 1) - ly_raw : ly_raw;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active_o <= 1'b0;
            hsync_o  <= 1'b1;
            vsync_o  <= 1'b1;
        end else begin
            active_o <= active_i;
            hsync_o  <= hsync_i;
            vsync_o  <= vsync_i;
        end
    end

    always_ff @(posedge clk) begin
        tile_o     <= tile;
        img_id_o   <= img_id_t'(tile % `NUM_IMAGES);
        img_addr_o <= pix_addr_t'(lx) + pix_addr_t'(ly) * pix_addr_t'(`TILE_W);
    end

endmodule

// File: vga_timing.sv
`timescale 1ns/1ps
`include "match_cfg.svh"

module vga_timing import match_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    output screen_t hcount_o,
    output screen_t vcount_o,
    output logic    active_o,
    output logic    hsync_o,
    output logic    vsync_o
);

    localparam screen_t HS_START = screen_t'(`H_ACTIVE + `H_FRONT);
    localparam screen_t HS_END   = screen_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam screen_t VS_START = screen_t'(`V_ACTIVE + `V_FRONT);
    localparam screen_t VS_END   = screen_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    screen_t h_nxt;
    screen_t v_nxt;

    always_comb begin
        h_nxt = (hcount_o == screen_t'(`H_TOTAL - 1)) ? '0 : hcount_o + 1'b1;
        v_nxt = vcount_o;
        if (hcount_o == screen_t'(`H_TOTAL - 1)) begin
            v_nxt = (vcount_o == screen_t'(`V_TOTAL - 1)) ? '0 : vcount_o + 1'b1;
        end
    end

    // Park on the last position so the first pixel after reset is (0, 0)
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcount_o <= screen_t'(`H_TOTAL - 1);
            vcount_o <= screen_t'(`V_TOTAL - 1);
            active_o <= 1'b0;
            hsync_o  <= 1'b1;
            vsync_o  <= 1'b1;
        end else begin
            hcount_o <= h_nxt;
            vcount_o <= v_nxt;
            active_o <= (h_nxt < screen_t'(`H_ACTIVE)) && (v_nxt < screen_t'(`V_ACTIVE));
            hsync_o  <= !(h_nxt >= HS_START && h_nxt < HS_END);
            vsync_o  <= !(v_nxt >= VS_START && v_nxt < VS_END);
        end
    end

endmodule
